// File: sim.f
common/mmu_pkg.sv
hw/pte_check.sv
tlb/tlb.sv
hw/walk_ctrl.sv
hw/mmu_top.sv
dv/mmu_props.sv
dv/mmu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the mmu testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module mmu_tb -o mmu_sim \
   && ./obj_dir/mmu_sim \
   || { echo "simulation failed"; exit 1; }

// File: dv/mmu_tb.sv
`timescale 1ns/1ps

module mmu_tb;

   localparam int N_ACCESS = 380;
   localparam logic [31:0] PT_BASE = 32'h0001_0000;
   localparam int PT_WORDS = 9 * 1024;
   localparam real WATCH_NS = (N_ACCESS * 20 + 600) * 8.0;

   typedef struct packed {
      logic        fault;
      logic [4:0]  code;
      logic [31:0] tval;
      logic [31:0] paddr;
      logic        write;
      logic [31:0] wdata;
      logic [3:0]  wstrb;
      logic [1:0]  nreq;
   } exp_t;

   logic                clk;
   logic                rstn;
   logic [31:0]         satp;
   mmu_pkg::priv_e      priv;
   logic                sum;
   logic                flush;
   logic                core_req_valid;
   mmu_pkg::core_req_t  core_req;
   logic                core_req_ready;
   logic                core_resp_valid;
   mmu_pkg::core_resp_t core_resp;
   logic                mem_req_valid;
   mmu_pkg::mem_req_t   mem_req;
   logic                mem_resp_valid;
   logic [31:0]         mem_resp_data;

   logic [31:0]         ptmem [PT_WORDS];
   logic [31:0]         rng;
   logic [31:0]         resp_rng;
   exp_t                exp_q [$];
   mmu_pkg::mem_req_t   req_log [$];
   logic [31:0]         pend_addr;
   int                  wait_cnt;

   // testbench copy of the tlb contents
   logic                m_valid [16];
   logic [19:0]         m_vpn [16];
   logic [19:0]         m_ppn [16];
   logic [4:0]          m_flags [16];

   mmu_top dut (.*);

   always #4 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic logic [31:0] addr_hash(input logic [31:0] a);
      return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
   endfunction

   function automatic logic [31:0] mem_word(input logic [31:0] a);
      if (a >= PT_BASE && a < PT_BASE + PT_WORDS * 4) begin
         return ptmem[(a - PT_BASE) >> 2];
      end
      return addr_hash(a);
   endfunction

   // 0 next level, 1 leaf ok, 2 fault; cause 0 fetch, 1 load, 2 store
   function automatic int classify(input logic [31:0] pte, input bit lvl, input int cause,
                                   input int pv, input bit sm);
      bit v = pte[0];
      bit r = pte[1];
      bit w = pte[2];
      bit x = pte[3];
      bit u = pte[4];
      bit right;
      bit pok;
      if (!v || (!r && w)) return 2;
      if (!r && !x) return lvl ? 0 : 2;
      right = (cause == 0) ? x : (cause == 1) ? r : w;
      pok = (pv == 0) ? u : (!u || sm);
      if (!right || !pok) return 2;
      if (lvl && pte[19:10] != 10'h0) return 2;
      return 1;
   endfunction

   function automatic logic [4:0] leaf_flags(input logic [3:0] rv);
      logic [4:0] f;
      f = {rv[3:0], 1'b1};
      if (!f[1] && !f[3]) f[1] = 1'b1;
      return f;
   endfunction

   task automatic check(input string name, input logic [31:0] expv, input logic [31:0] act);
      if (expv !== act) begin
         $display("** Error at %0t ns: %s expected %h actual %h", $time, name, expv, act);
         $display("TEST RESULT: FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic build_tables();
      logic [31:0] pte;
      int k;
      for (int i = 0; i < PT_WORDS; i++) begin
         ptmem[i] = addr_hash(PT_BASE + i * 4) & ~32'h1;
      end
      for (int v1 = 0; v1 < 8; v1++) begin
         rng = xorshift(rng);
         k = rng % 8;
         rng = xorshift(rng);
         case (k)
            0: pte = {rng[31:1], 1'b0};
            1: pte = 32'h0000_0005;
            2, 3: pte = {2'b00, 1'b1, rng[8:0], 10'h0, 5'h0, leaf_flags(rng[31:28])};
            4: pte = {2'b00, 1'b1, rng[8:0], 1'b1, rng[18:10], 5'h0, leaf_flags(rng[31:28])};
            default: pte = {2'b00, 20'h00011 + 20'(v1), 10'h001};
         endcase
         ptmem[v1] = pte;
         for (int v0 = 0; v0 < 8; v0++) begin
            rng = xorshift(rng);
            k = rng % 8;
            rng = xorshift(rng);
            case (k)
               0: pte = {rng[31:1], 1'b0};
               1: pte = {2'b00, 1'b1, rng[18:0], 10'h001};
               default: pte = {2'b00, 1'b1, rng[18:0], 5'h0, leaf_flags(rng[31:28])};
            endcase
            ptmem[(v1 + 1) * 1024 + v0] = pte;
         end
      end
   endtask

   // predicts one access and updates the tlb copy
   task automatic model_access(input logic [31:0] va, input int cause,
                               input logic [31:0] wd, input logic [3:0] ws);
      exp_t e;
      logic [31:0] p1;
      logic [31:0] p0;
      logic [31:0] leaf;
      int c;
      int slot;
      int hit;
      e = '0;
      e.tval = va;
      e.write = (cause == 2);
      e.wdata = wd;
      e.wstrb = ws;
      e.code = (cause == 0) ? 5'd12 : (cause == 1) ? 5'd13 : 5'd15;
      hit = -1;
      for (int i = 0; i < 16; i++) begin
         if (m_valid[i] && m_vpn[i] == va[31:12]) hit = i;
      end
      if (!satp[31] || priv == mmu_pkg::PRIV_M) begin
         e.nreq = 1;
         e.paddr = va;
      end else if (hit >= 0) begin
         c = classify({2'b00, m_ppn[hit], 5'h0, m_flags[hit]}, 0, cause, int'(priv), sum);
         e.nreq = (c == 1) ? 1 : 0;
         e.fault = (c != 1);
         e.paddr = {m_ppn[hit], va[11:0]};
      end else begin
         p1 = mem_word({satp[19:0], 12'h0} + {20'h0, va[31:22], 2'b00});
         e.nreq = 1;
         c = classify(p1, 1, cause, int'(priv), sum);
         leaf = p1;
         e.paddr = {p1[29:20], va[21:0]};
         if (c == 0) begin
            p0 = mem_word({p1[29:10], 12'h0} + {20'h0, va[21:12], 2'b00});
            e.nreq = 2;
            c = classify(p0, 0, cause, int'(priv), sum);
            leaf = p0;
            e.paddr = {p0[29:10], va[11:0]};
         end
         e.fault = (c != 1);
         if (c == 1) begin
            e.nreq = e.nreq + 1;
            slot = 0;
            for (int i = 15; i >= 0; i--) begin
               if (!m_valid[i]) slot = i;
            end
            m_valid[slot] = 1'b1;
            m_vpn[slot] = va[31:12];
            m_ppn[slot] = e.paddr[31:12];
            m_flags[slot] = leaf[4:0];
         end
      end
      exp_q.push_back(e);
   endtask

   // request stays valid until the dut takes it
   task automatic send(input logic [31:0] va, input int cause);
      logic [31:0] wd;
      logic [3:0] ws;
      rng = xorshift(rng);
      wd = rng;
      ws = rng[7:4];
      model_access(va, cause, wd, ws);
      core_req_valid <= 1'b1;
      core_req <= '{cause: mmu_pkg::access_e'(cause), addr: va, wdata: wd, wstrb: ws};
      do @(posedge clk); while (!core_req_ready);
   endtask

   task automatic drain();
      core_req_valid <= 1'b0;
      while (exp_q.size() != 0) @(posedge clk);
      repeat (2) @(posedge clk);
   endtask

   task automatic run_random(input int n, input bit full_addr);
      logic [31:0] va;
      logic [31:0] last_va;
      last_va = 32'h0;
      for (int i = 0; i < n; i++) begin
         rng = xorshift(rng);
         if (full_addr) va = rng;
         else if (rng[31:30] == 2'b00 && i > 0) va = last_va;
         else va = {7'h0, rng[2:0], 7'h0, rng[5:3], rng[17:6]};
         last_va = va;
         rng = xorshift(rng);
         send(va, rng % 3);
      end
      drain();
   endtask

   ////////////////////////////////////////
   // memory responder and checker
   ////////////////////////////////////////

   always @(posedge clk) begin
      if (rstn) begin
         wait_cnt = 0;
         mem_resp_valid <= 1'b0;
      end else begin
         mem_resp_valid <= 1'b0;
         if (mem_req_valid) begin
            resp_rng = xorshift(resp_rng);
            pend_addr = mem_req.addr;
            wait_cnt = 1 + resp_rng % 4;
         end else if (wait_cnt != 0) begin
            wait_cnt = wait_cnt - 1;
            if (wait_cnt == 0) begin
               mem_resp_valid <= 1'b1;
               mem_resp_data <= mem_word(pend_addr);
            end
         end
      end
   end

   always @(posedge clk) begin
      exp_t e;
      mmu_pkg::mem_req_t last;
      if (!rstn) begin
         if (mem_req_valid) req_log.push_back(mem_req);
         if (core_resp_valid) begin
            if (exp_q.size() == 0) begin
               $display("response arrived with no access outstanding at %0t ns", $time);
               $display("TEST RESULT: FAIL");
               $fatal(1, "unexpected response");
            end
            e = exp_q.pop_front();
            check("core_resp.fault", 32'(e.fault), 32'(core_resp.fault));
            check("mem_req count", 32'(e.nreq), req_log.size());
            if (e.fault) begin
               check("core_resp.code", 32'(e.code), 32'(core_resp.code));
               check("core_resp.tval", e.tval, core_resp.tval);
               check("core_resp.rdata", 32'h0, core_resp.rdata);
            end else begin
               last = req_log[req_log.size() - 1];
               check("mem_req.addr", e.paddr, last.addr);
               check("mem_req.write", 32'(e.write), 32'(last.write));
               check("mem_req.wdata", e.wdata, last.wdata);
               check("mem_req.wstrb", 32'(e.wstrb), 32'(last.wstrb));
               check("core_resp.rdata", mem_word(e.paddr), core_resp.rdata);
            end
            req_log.delete();
         end
      end
   end

   initial begin
      #(WATCH_NS);
      $display("timeout: the accesses did not complete in the allowed time");
      $display("TEST RESULT: FAIL");
      $fatal(1, "watchdog expired");
   end

   initial begin
      clk = 1'b0;
      rstn = 1'b1;
      satp = 32'h0;
      priv = mmu_pkg::PRIV_S;
      sum = 1'b0;
      flush = 1'b0;
      core_req_valid = 1'b0;
      core_req = '0;
      mem_resp_valid = 1'b0;
      mem_resp_data = 32'h0;
      rng = 32'hdb35_5ed4;
      resp_rng = xorshift(32'hdb35_5ed4 ^ 32'h0f0f_0f0f);
      for (int i = 0; i < 16; i++) m_valid[i] = 1'b0;
      build_tables();
      repeat (10) @(posedge clk);
      rstn <= 1'b0;
      repeat (2) @(posedge clk);
      // bare mode, then machine mode with sv32 on
      run_random(40, 1);
      satp <= {1'b1, 11'h0, 20'h00010};
      priv <= mmu_pkg::PRIV_M;
      @(posedge clk);
      run_random(40, 1);
      priv <= mmu_pkg::PRIV_S;
      @(posedge clk);
      run_random(80, 0);
      sum <= 1'b1;
      @(posedge clk);
      run_random(80, 0);
      priv <= mmu_pkg::PRIV_U;
      @(posedge clk);
      run_random(80, 0);
      flush <= 1'b1;
      @(posedge clk);
      flush <= 1'b0;
      for (int i = 0; i < 16; i++) m_valid[i] = 1'b0;
      priv <= mmu_pkg::PRIV_S;
      @(posedge clk);
      run_random(60, 0);
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

// File: dv/mmu_props.sv
`timescale 1ns/1ps

module mmu_props (
   input logic clk,
   input logic rstn,
   input logic core_req_ready,
   input logic core_resp_valid,
   input logic mem_req_valid,
   input logic mem_resp_valid
);

   logic outstanding;

   always_ff @(posedge clk) begin
      if (rstn) outstanding <= 1'b0;
      else if (mem_req_valid) outstanding <= 1'b1;
      else if (mem_resp_valid) outstanding <= 1'b0;
   end

   a_req_pulse: assert property (@(posedge clk) disable iff (rstn)
      mem_req_valid |=> !mem_req_valid) else $error("mem_req_valid longer than one cycle");

   a_single: assert property (@(posedge clk) disable iff (rstn)
      mem_req_valid |-> !outstanding) else $error("second memory request outstanding");

   a_resp_idle: assert property (@(posedge clk) disable iff (rstn)
      !(core_resp_valid && core_req_ready)) else $error("response while ready");

   a_after_reset: assert property (@(posedge clk)
      $fell(rstn) |-> core_req_ready && !core_resp_valid && !mem_req_valid)
      else $error("outputs wrong after reset");

endmodule

bind walk_ctrl mmu_props u_props (
   .clk             (clk),
   .rstn            (rstn),
   .core_req_ready  (core_req_ready),
   .core_resp_valid (core_resp_valid),
   .mem_req_valid   (mem_req_valid),
   .mem_resp_valid  (mem_resp_valid)
);

// File: hw/mmu_top.sv
`timescale 1ns/1ps

module mmu_top (
   input  logic                clk,
   input  logic                rstn,
   input  logic [31:0]         satp,
   input  mmu_pkg::priv_e      priv,
   input  logic                sum,
   input  logic                flush,
   input  logic                core_req_valid,
   input  mmu_pkg::core_req_t  core_req,
   output logic                core_req_ready,
   output logic                core_resp_valid,
   output mmu_pkg::core_resp_t core_resp,
   output logic                mem_req_valid,
   output mmu_pkg::mem_req_t   mem_req,
   input  logic                mem_resp_valid,
   input  logic [31:0]         mem_resp_data
);

   logic [mmu_pkg::VPN_W-1:0] tlb_lookup_vpn;
   logic                      tlb_hit;
   mmu_pkg::tlb_entry_t       tlb_hit_entry;
   logic                      tlb_fill;
   mmu_pkg::tlb_entry_t       tlb_fill_entry;
   logic [31:0]               check_pte;
   logic                      check_level;
   mmu_pkg::access_e          check_cause;
   mmu_pkg::priv_e            check_priv;
   logic                      check_sum;
   mmu_pkg::pte_class_e       pte_class;

   walk_ctrl u_walk_ctrl (
      .clk            (clk),
      .rstn           (rstn),
      .satp           (satp),
      .priv           (priv),
      .sum            (sum),
      .core_req_valid (core_req_valid),
      .core_req       (core_req),
      .mem_resp_valid (mem_resp_valid),
      .mem_resp_data  (mem_resp_data),
      .tlb_hit        (tlb_hit),
      .tlb_hit_entry  (tlb_hit_entry),
      .pte_class      (pte_class),
      .core_req_ready (core_req_ready),
      .core_resp_valid(core_resp_valid),
      .core_resp      (core_resp),
      .mem_req_valid  (mem_req_valid),
      .mem_req        (mem_req),
      .tlb_lookup_vpn (tlb_lookup_vpn),
      .tlb_fill       (tlb_fill),
      .tlb_fill_entry (tlb_fill_entry),
      .check_pte      (check_pte),
      .check_level    (check_level),
      .check_cause    (check_cause),
      .check_priv     (check_priv),
      .check_sum      (check_sum)
   );

   tlb u_tlb (
      .clk        (clk),
      .rstn       (rstn),
      .flush      (flush),
      .lookup_vpn (tlb_lookup_vpn),
      .fill       (tlb_fill),
      .fill_entry (tlb_fill_entry),
      .hit        (tlb_hit),
      .hit_entry  (tlb_hit_entry)
   );

   pte_check u_pte_check (
      .pte       (check_pte),
      .level     (check_level),
      .cause     (check_cause),
      .priv      (check_priv),
      .sum       (check_sum),
      .pte_class (pte_class)
   );

endmodule

// File: hw/walk_ctrl.sv
`timescale 1ns/1ps

module walk_ctrl (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic [31:0]               satp,
   input  mmu_pkg::priv_e            priv,
   input  logic                      sum,
   input  logic                      core_req_valid,
   input  mmu_pkg::core_req_t        core_req,
   input  logic                      mem_resp_valid,
   input  logic [31:0]               mem_resp_data,
   input  logic                      tlb_hit,
   input  mmu_pkg::tlb_entry_t       tlb_hit_entry,
   input  mmu_pkg::pte_class_e       pte_class,
   output logic                      core_req_ready,
   output logic                      core_resp_valid,
   output mmu_pkg::core_resp_t       core_resp,
   output logic                      mem_req_valid,
   output mmu_pkg::mem_req_t         mem_req,
   output logic [mmu_pkg::VPN_W-1:0] tlb_lookup_vpn,
   output logic                      tlb_fill,
   output mmu_pkg::tlb_entry_t       tlb_fill_entry,
   output logic [31:0]               check_pte,
   output logic                      check_level,
   output mmu_pkg::access_e          check_cause,
   output mmu_pkg::priv_e            check_priv,
   output logic                      check_sum
);

   localparam int OFS = mmu_pkg::PAGE_OFS_W;

   mmu_pkg::walk_state_e state;
   mmu_pkg::core_req_t   req_q;
   mmu_pkg::priv_e       priv_q;
   logic                 sum_q;
   logic                 accept;
   logic                 bypass;
   logic [31:0]          hit_pte;
   logic [31:0]          leaf_paddr;

   function automatic mmu_pkg::exc_code_e fault_code(input mmu_pkg::access_e cause);
      case (cause)
         mmu_pkg::ACC_FETCH: return mmu_pkg::EXC_INSTR_PF;
         mmu_pkg::ACC_STORE: return mmu_pkg::EXC_STORE_PF;
         default:            return mmu_pkg::EXC_LOAD_PF;
      endcase
   endfunction

   function automatic mmu_pkg::mem_req_t data_req(input mmu_pkg::core_req_t r,
                                                  input logic [31:0] paddr);
      return '{write: (r.cause == mmu_pkg::ACC_STORE), addr: paddr,
               wdata: r.wdata, wstrb: r.wstrb};
   endfunction

   function automatic mmu_pkg::mem_req_t pte_req(input logic [31:0] addr);
      return '{write: 1'b0, addr: addr, wdata: 32'h0, wstrb: 4'h0};
   endfunction

   function automatic mmu_pkg::core_resp_t fault_resp(input mmu_pkg::core_req_t r);
      return '{fault: 1'b1, code: fault_code(r.cause), tval: r.addr, rdata: 32'h0};
   endfunction

   assign core_req_ready = (state == mmu_pkg::ST_IDLE);
   assign accept         = core_req_valid && core_req_ready;
   assign bypass         = !satp[mmu_pkg::SATP_MODE_BIT] || (priv == mmu_pkg::PRIV_M);
   assign tlb_lookup_vpn = core_req.addr[31:OFS];

   // cached flags rebuilt as a level-0 pte
   always_comb begin
      hit_pte                 = '0;
      hit_pte[29:10]          = tlb_hit_entry.ppn;
      hit_pte[mmu_pkg::PTE_V] = tlb_hit_entry.v;
      hit_pte[mmu_pkg::PTE_R] = tlb_hit_entry.r;
      hit_pte[mmu_pkg::PTE_W] = tlb_hit_entry.w;
      hit_pte[mmu_pkg::PTE_X] = tlb_hit_entry.x;
      hit_pte[mmu_pkg::PTE_U] = tlb_hit_entry.u;
   end

   // checker sees the new request in idle, the walked pte afterwards
   always_comb begin
      if (state == mmu_pkg::ST_IDLE) begin
         check_pte   = hit_pte;
         check_level = 1'b0;
         check_cause = core_req.cause;
         check_priv  = priv;
         check_sum   = sum;
      end else begin
         check_pte   = mem_resp_data;
         check_level = (state == mmu_pkg::ST_PTE1);
         check_cause = req_q.cause;
         check_priv  = priv_q;
         check_sum   = sum_q;
      end
   end

   // superpage keeps vpn0 from the virtual address
   assign leaf_paddr = (state == mmu_pkg::ST_PTE1) ?
                       {mem_resp_data[29:20], req_q.addr[21:0]} :
                       {mem_resp_data[29:10], req_q.addr[OFS-1:0]};

   ////////////////////////////////////////
   // walk fsm
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rstn) begin
         state           <= mmu_pkg::ST_IDLE;
         core_resp_valid <= 1'b0;
         mem_req_valid   <= 1'b0;
         tlb_fill        <= 1'b0;
      end else begin
         core_resp_valid <= 1'b0;
         mem_req_valid   <= 1'b0;
         tlb_fill        <= 1'b0;
         case (state)
            mmu_pkg::ST_IDLE: begin
               if (accept) begin
                  req_q  <= core_req;
                  priv_q <= priv;
                  sum_q  <= sum;
                  if (bypass) begin
                     mem_req_valid <= 1'b1;
                     mem_req       <= data_req(core_req, core_req.addr);
                     state         <= mmu_pkg::ST_DATA;
                  end else if (tlb_hit && pte_class == mmu_pkg::PTE_LEAF_OK) begin
                     mem_req_valid <= 1'b1;
                     mem_req       <= data_req(core_req,
                                               {tlb_hit_entry.ppn, core_req.addr[OFS-1:0]});
                     state         <= mmu_pkg::ST_DATA;
                  end else if (tlb_hit) begin
                     core_resp_valid <= 1'b1;
                     core_resp       <= fault_resp(core_req);
                     state           <= mmu_pkg::ST_DONE;
                  end else begin
                     mem_req_valid <= 1'b1;
                     mem_req       <= pte_req({satp[19:0], 12'h000} +
                                              {20'h0, core_req.addr[31:22], 2'b00});
                     state         <= mmu_pkg::ST_PTE1;
                  end
               end
            end
            mmu_pkg::ST_PTE1, mmu_pkg::ST_PTE0: begin
               if (mem_resp_valid) begin
                  if (pte_class == mmu_pkg::PTE_NEXT) begin
                     mem_req_valid <= 1'b1;
                     mem_req       <= pte_req({mem_resp_data[29:10], 12'h000} +
                                              {20'h0, req_q.addr[21:12], 2'b00});
                     state         <= mmu_pkg::ST_PTE0;
                  end else if (pte_class == mmu_pkg::PTE_LEAF_OK) begin
                     mem_req_valid  <= 1'b1;
                     mem_req        <= data_req(req_q, leaf_paddr);
                     tlb_fill       <= 1'b1;
                     tlb_fill_entry <= '{valid: 1'b1,
                                         vpn:   req_q.addr[31:OFS],
                                         ppn:   leaf_paddr[31:OFS],
                                         v:     mem_resp_data[mmu_pkg::PTE_V],
                                         r:     mem_resp_data[mmu_pkg::PTE_R],
                                         w:     mem_resp_data[mmu_pkg::PTE_W],
                                         x:     mem_resp_data[mmu_pkg::PTE_X],
                                         u:     mem_resp_data[mmu_pkg::PTE_U]};
                     state          <= mmu_pkg::ST_DATA;
                  end else begin
                     core_resp_valid <= 1'b1;
                     core_resp       <= fault_resp(req_q);
                     state           <= mmu_pkg::ST_DONE;
                  end
               end
            end
            mmu_pkg::ST_DATA: begin
               if (mem_resp_valid) begin
                  core_resp_valid <= 1'b1;
                  core_resp       <= '{fault: 1'b0, code: fault_code(req_q.cause),
                                       tval: req_q.addr, rdata: mem_resp_data};
                  state           <= mmu_pkg::ST_DONE;
               end
            end
            default: state <= mmu_pkg::ST_IDLE;
         endcase
      end
   end

endmodule

// File: tlb/tlb.sv
`timescale 1ns/1ps

module tlb (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic                      flush,
   input  logic [mmu_pkg::VPN_W-1:0] lookup_vpn,
   input  logic                      fill,
   input  mmu_pkg::tlb_entry_t       fill_entry,
   output logic                      hit,
   output mmu_pkg::tlb_entry_t       hit_entry
);

   mmu_pkg::tlb_entry_t           entries [mmu_pkg::TLB_ENTRIES];
   logic                          present;
   logic [mmu_pkg::TLB_IDX_W-1:0] fill_idx;

   // parallel tag compare
   always_comb begin
      hit       = 1'b0;
      hit_entry = '0;
      for (int i = mmu_pkg::TLB_ENTRIES - 1; i >= 0; i--) begin
         if (entries[i].valid && entries[i].vpn == lookup_vpn) begin
            hit       = 1'b1;
            hit_entry = entries[i];
         end
      end
   end

   // lowest free slot, slot 0 when full
   always_comb begin
      present  = 1'b0;
      fill_idx = '0;
      for (int i = mmu_pkg::TLB_ENTRIES - 1; i >= 0; i--) begin
         if (entries[i].valid && entries[i].vpn == fill_entry.vpn) begin
            present = 1'b1;
         end
         if (!entries[i].valid) begin
            fill_idx = i[mmu_pkg::TLB_IDX_W-1:0];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rstn || flush) begin
         for (int i = 0; i < mmu_pkg::TLB_ENTRIES; i++) begin
            entries[i].valid <= 1'b0;
         end
      end else if (fill && !present) begin
         entries[fill_idx] <= fill_entry;
      end
   end

endmodule

// File: hw/pte_check.sv
`timescale 1ns/1ps

module pte_check (
   input  logic                [31:0] pte,
   input  logic                       level,
   input  mmu_pkg::access_e           cause,
   input  mmu_pkg::priv_e             priv,
   input  logic                       sum,
   output mmu_pkg::pte_class_e        pte_class
);

   logic invalid;
   logic leaf;
   logic right_ok;
   logic priv_ok;
   logic misaligned;

   // w without r is reserved
   assign invalid = !pte[mmu_pkg::PTE_V] || (!pte[mmu_pkg::PTE_R] && pte[mmu_pkg::PTE_W]);
   assign leaf    = pte[mmu_pkg::PTE_R] || pte[mmu_pkg::PTE_X];

   always_comb begin
      case (cause)
         mmu_pkg::ACC_FETCH: right_ok = pte[mmu_pkg::PTE_X];
         mmu_pkg::ACC_LOAD:  right_ok = pte[mmu_pkg::PTE_R];
         mmu_pkg::ACC_STORE: right_ok = pte[mmu_pkg::PTE_W];
         default:            right_ok = 1'b0;
      endcase
   end

   // supervisor reaches user pages only with sum
   always_comb begin
      case (priv)
         mmu_pkg::PRIV_U: priv_ok = pte[mmu_pkg::PTE_U];
         mmu_pkg::PRIV_S: priv_ok = !pte[mmu_pkg::PTE_U] || sum;
         default:         priv_ok = 1'b1;
      endcase
   end

   assign misaligned = level && (pte[19:10] != 10'h0);

   always_comb begin
      if (invalid) begin
         pte_class = mmu_pkg::PTE_FAULT;
      end else if (!leaf) begin
         pte_class = level ? mmu_pkg::PTE_NEXT : mmu_pkg::PTE_FAULT;
      end else if (!right_ok || !priv_ok || misaligned) begin
         pte_class = mmu_pkg::PTE_FAULT;
      end else begin
         pte_class = mmu_pkg::PTE_LEAF_OK;
      end
   end

endmodule

// File: common/mmu_pkg.sv
package mmu_pkg;

   ////////////////////////////////////////
   // sizes and bit positions
   ////////////////////////////////////////

   localparam int TLB_ENTRIES   = 16;
   localparam int TLB_IDX_W     = 4;
   localparam int VPN_W         = 20;
   localparam int PPN_W         = 20;
   localparam int PAGE_OFS_W    = 12;
   localparam int SATP_MODE_BIT = 31;

   // pte flag bits
   localparam int PTE_V = 0;
   localparam int PTE_R = 1;
   localparam int PTE_W = 2;
   localparam int PTE_X = 3;
   localparam int PTE_U = 4;

   ////////////////////////////////////////
   // enums
   ////////////////////////////////////////

   typedef enum logic [1:0] {
      ACC_FETCH = 2'd0,
      ACC_LOAD  = 2'd1,
      ACC_STORE = 2'd2
   } access_e;

   typedef enum logic [1:0] {
      PRIV_U = 2'd0,
      PRIV_S = 2'd1,
      PRIV_M = 2'd3
   } priv_e;

   typedef enum logic [4:0] {
      EXC_INSTR_PF = 5'd12,
      EXC_LOAD_PF  = 5'd13,
      EXC_STORE_PF = 5'd15
   } exc_code_e;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_PTE1,
      ST_PTE0,
      ST_DATA,
      ST_DONE
   } walk_state_e;

   typedef enum logic [1:0] {
      PTE_NEXT,
      PTE_LEAF_OK,
      PTE_FAULT
   } pte_class_e;

   ////////////////////////////////////////
   // structs
   ////////////////////////////////////////

   typedef struct packed {
      access_e     cause;
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [3:0]  wstrb;
   } core_req_t;

   typedef struct packed {
      logic        fault;
      exc_code_e   code;
      logic [31:0] tval;
      logic [31:0] rdata;
   } core_resp_t;

   typedef struct packed {
      logic        write;
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [3:0]  wstrb;
   } mem_req_t;

   // one 4 KB translation with its leaf flags
   typedef struct packed {
      logic             valid;
      logic [VPN_W-1:0] vpn;
      logic [PPN_W-1:0] ppn;
      logic             v;
      logic             r;
      logic             w;
      logic             x;
      logic             u;
   } tlb_entry_t;

endpackage
